// ==== verilog/rename_settings.svh ====
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Sizes of the FP rename stage, fixed by the core

// Physical FP register file
`define NUM_PHYSICAL_FREGISTERS 64

// Architectural FP registers f0..f31
`define NUM_ISA_REGISTERS 32

// Checkpoint slots of the free list and map table
// One slot is always the working copy, so at most 3 are live
`define NUM_CHECKPOINTS 4

// Free ring depth follows from the two register counts

`endif

// ==== verilog/rename_pkg.sv ====
`include "rename_settings.svh"

package rename_pkg;

    // Register and label indices
    typedef logic [$clog2(`NUM_PHYSICAL_FREGISTERS)-1:0] phfreg_t; // Physical FP reg
    typedef logic [$clog2(`NUM_ISA_REGISTERS)-1:0]       areg_t;   // Architectural FP reg
    typedef logic [$clog2(`NUM_CHECKPOINTS)-1:0]         checkpoint_ptr; // Checkpoint label

    // Branch unit verdict on a checkpointed branch
    typedef enum logic [1:0] {
        RES_NONE       = 2'b00, // Nothing resolved this cycle
        RES_CORRECT    = 2'b01, // Oldest checkpoint can be released
        RES_MISPREDICT = 2'b10  // Restore the labelled checkpoint
    } resolve_op_e;

    // Front end request, one instruction per cycle
    typedef struct packed {
        logic  valid;
        areg_t src1;
        areg_t src2;
        areg_t dst;
        logic  dst_valid; // Instruction writes an FP register
        logic  is_branch; // Take a checkpoint
    } rename_req_t;

    // Renamed operands back to the front end
    typedef struct packed {
        phfreg_t       psrc1;
        phfreg_t       psrc2;
        phfreg_t       pdst;       // Newly allocated destination
        phfreg_t       old_pdst;   // Previous mapping of dst, freed at commit
        checkpoint_ptr checkpoint; // Label to quote on resolve
    } rename_resp_t;

    typedef struct packed {
        resolve_op_e   op;
        checkpoint_ptr label;
    } resolve_t;

    // Reorder buffer commit of one FP destination
    typedef struct packed {
        logic    valid;
        logic    exception; // Flush everything speculative
        areg_t   areg;
        phfreg_t pdst;
        phfreg_t old_pdst;
    } commit_t;

endpackage

// ==== verilog/fp_free_list.sv ====
`timescale 1ns/1ps
`include "rename_settings.svh"

module fp_free_list import rename_pkg::*; (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          read_head_i,          // Pop one free register
    input  logic          add_free_register_i,  // Push a committed old_pdst
    input  phfreg_t       free_register_i,
    input  logic          do_checkpoint_i,      // Snapshot head and count
    input  logic          do_recover_i,         // Switch back to a snapshot
    input  logic          delete_checkpoint_i,  // Oldest snapshot released
    input  checkpoint_ptr recover_checkpoint_i,
    input  logic          commit_roll_back_i,   // Exception, all in-flight regs return
    output phfreg_t       new_register_o,
    output checkpoint_ptr checkpoint_o,         // Working version, label of a branch now
    output logic          out_of_checkpoints_o,
    output logic          empty_o
);

    localparam int NUM_ENTRIES = `NUM_PHYSICAL_FREGISTERS - `NUM_ISA_REGISTERS; // Ring depth
    localparam int PTR_W       = $clog2(NUM_ENTRIES);

    typedef logic [PTR_W-1:0]                  ring_ptr_t;
    typedef logic [PTR_W:0]                    ring_cnt_t; // One bit wider, holds a full ring
    typedef logic [$clog2(`NUM_CHECKPOINTS):0] ckpt_cnt_t;

    phfreg_t       ring [0:NUM_ENTRIES-1];          // Free register storage
    ring_ptr_t     head [0:`NUM_CHECKPOINTS-1];     // Head per version
    ring_cnt_t     num_free [0:`NUM_CHECKPOINTS-1]; // Free count per version
    ring_ptr_t     tail;                            // Shared by all versions
    checkpoint_ptr version_head;                    // Working version
    checkpoint_ptr version_tail;                    // Oldest live snapshot
    checkpoint_ptr next_version;
    ckpt_cnt_t     num_checkpoints;                 // Live snapshots

    logic write_en;
    logic read_en;
    logic ckpt_en;

    assign next_version = version_head + 1'b1;

    // Rollback discards pushes, recover and rollback discard pops and snapshots
    assign write_en = add_free_register_i & ~commit_roll_back_i;
    assign read_en  = read_head_i & ((num_free[version_head] != '0) | write_en)
                    & ~do_recover_i & ~commit_roll_back_i;
    assign ckpt_en  = do_checkpoint_i & (num_checkpoints < (`NUM_CHECKPOINTS - 1))
                    & ~do_recover_i & ~commit_roll_back_i;

    //////////////////////////////////////////////////////////////////////
    // Ring storage, preloaded with the registers not mapped at reset
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                ring[i] <= phfreg_t'(i + `NUM_ISA_REGISTERS); // p32..p63
            end
        end else if (write_en) begin
            ring[tail] <= free_register_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers, counts and versions
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `NUM_CHECKPOINTS; i++) begin
                head[i]     <= '0;
                num_free[i] <= ring_cnt_t'(NUM_ENTRIES);
            end
            tail            <= '0;
            version_head    <= '0;
            version_tail    <= '0;
            num_checkpoints <= '0;
        end else if (commit_roll_back_i) begin
            // Nothing speculative survives, whole ring is free again
            head[0]         <= tail;
            num_free[0]     <= ring_cnt_t'(NUM_ENTRIES);
            version_head    <= '0;
            version_tail    <= '0;
            num_checkpoints <= '0;
        end else begin
            tail         <= tail + write_en;
            version_tail <= version_tail + delete_checkpoint_i;

            // A freed register is free in every version
            for (int i = 0; i < `NUM_CHECKPOINTS; i++) begin
                num_free[i] <= num_free[i] + write_en;
            end

            if (do_recover_i) begin
                version_head    <= recover_checkpoint_i;
                // Snapshots older than the recovered one stay live
                num_checkpoints <= ckpt_cnt_t'(checkpoint_ptr'(recover_checkpoint_i
                                                              - version_tail));
            end else begin
                num_checkpoints        <= num_checkpoints + ckpt_en - delete_checkpoint_i;
                head[version_head]     <= head[version_head] + read_en;
                num_free[version_head] <= num_free[version_head] + write_en - read_en;

                if (ckpt_en) begin
                    // Current slot freezes, work carries on in the next one
                    version_head           <= next_version;
                    head[next_version]     <= head[version_head] + read_en;
                    num_free[next_version] <= num_free[version_head] + write_en - read_en;
                end
            end
        end
    end

    // Bypass the pushed register when the ring is drained
    assign new_register_o = ((num_free[version_head] == '0) & write_en) ? free_register_i
                                                                        : ring[head[version_head]];
    assign checkpoint_o         = version_head;
    assign empty_o              = (num_free[version_head] == '0) & ~write_en;
    assign out_of_checkpoints_o = (num_checkpoints == (`NUM_CHECKPOINTS - 1));

    //////////////////////////////////////////////////////////////////////
    // Checks on the controller's stall logic
    //////////////////////////////////////////////////////////////////////

    // Controller must stall a destination while nothing is free
    assert property (@(posedge clk_i) disable iff (!rstn_i) read_head_i |-> !empty_o);

    // Controller must stall a branch when all snapshots are live
    assert property (@(posedge clk_i) disable iff (!rstn_i)
                     do_checkpoint_i |-> !out_of_checkpoints_o);

endmodule

// ==== verilog/fp_rename_table.sv ====
`timescale 1ns/1ps
`include "rename_settings.svh"

module fp_rename_table import rename_pkg::*; (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  areg_t         src1_i,
    input  areg_t         src2_i,
    input  areg_t         dst_i,
    input  logic          map_write_i,        // Accepted rename with destination
    input  phfreg_t       new_preg_i,
    input  logic          checkpoint_i,       // Accepted branch
    input  checkpoint_ptr checkpoint_label_i, // Slot the free list freezes
    input  logic          recover_i,          // Mispredict
    input  checkpoint_ptr recover_label_i,
    input  logic          roll_back_i,        // Excepting commit
    input  logic          commit_write_i,
    input  areg_t         commit_areg_i,
    input  phfreg_t       commit_preg_i,
    output phfreg_t       psrc1_o,
    output phfreg_t       psrc2_o,
    output phfreg_t       old_pdst_o
);

    // Whole map as one vector so copies are single assignments
    typedef phfreg_t [`NUM_ISA_REGISTERS-1:0] map_t;

    map_t spec_map;                          // Speculative map
    map_t next_map;                          // Spec map after this cycle's write
    map_t commit_map;                        // Architectural state
    map_t commit_next;                       // Committed map after this cycle's commit
    map_t ckpt_map [0:`NUM_CHECKPOINTS-1];   // Snapshots per label

    //////////////////////////////////////////////////////////////////////
    // Lookups, old mapping for a same-cycle write
    //////////////////////////////////////////////////////////////////////

    assign psrc1_o    = spec_map[src1_i];
    assign psrc2_o    = spec_map[src2_i];
    assign old_pdst_o = spec_map[dst_i];  // Returned to the free list at commit

    always_comb begin
        next_map = spec_map;
        if (map_write_i) begin
            next_map[dst_i] = new_preg_i;
        end
    end

    // Commit write merged so a rollback sees it in the same edge
    always_comb begin
        commit_next = commit_map;
        if (commit_write_i) begin
            commit_next[commit_areg_i] = commit_preg_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Speculative and committed maps
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `NUM_ISA_REGISTERS; i++) begin
                spec_map[i]   <= phfreg_t'(i); // fN -> pN
                commit_map[i] <= phfreg_t'(i);
            end
        end else begin
            commit_map <= commit_next;
            if (roll_back_i) begin           // Exception wins over a mispredict
                spec_map <= commit_next;
            end else if (recover_i) begin
                spec_map <= ckpt_map[recover_label_i];
            end else begin
                spec_map <= next_map;
            end
        end
    end

    // Snapshot holds the map including the branch's own write
    always_ff @(posedge clk_i) begin
        if (checkpoint_i) begin
            ckpt_map[checkpoint_label_i] <= next_map;
        end
    end

    // A recover never lands in the same edge as a new snapshot
    assert property (@(posedge clk_i) disable iff (!rstn_i)
                     recover_i |-> !checkpoint_i && !map_write_i);

endmodule

// ==== verilog/fp_rename_ctrl.sv ====
`timescale 1ns/1ps

module fp_rename_ctrl import rename_pkg::*; (
    input  rename_req_t rename_i,
    input  resolve_t    resolve_i,
    input  commit_t     commit_i,
    input  logic        empty_i,
    input  logic        out_of_checkpoints_i,
    // Free list strobes
    output logic        read_head_o,
    output logic        do_checkpoint_o,
    output logic        do_recover_o,
    output logic        delete_checkpoint_o,
    output logic        add_free_register_o,
    output logic        commit_roll_back_o,
    // Map table strobes
    output logic        map_write_o,
    output logic        checkpoint_o,
    output logic        recover_o,
    output logic        roll_back_o,
    output logic        stall_o               // Front end holds its request
);

    logic mispredict;
    logic rollback;
    logic accept;

    assign mispredict = (resolve_i.op == RES_MISPREDICT);
    assign rollback   = commit_i.valid & commit_i.exception;

    // No free register, no free snapshot, or a flush in progress
    assign stall_o = (rename_i.valid & rename_i.dst_valid & empty_i)
                   | (rename_i.valid & rename_i.is_branch & out_of_checkpoints_i)
                   | mispredict | rollback;

    assign accept = rename_i.valid & ~stall_o;

    assign read_head_o         = accept & rename_i.dst_valid;
    assign map_write_o         = accept & rename_i.dst_valid;
    assign do_checkpoint_o     = accept & rename_i.is_branch;
    assign checkpoint_o        = accept & rename_i.is_branch;
    assign do_recover_o        = mispredict;
    assign recover_o           = mispredict;
    assign delete_checkpoint_o = (resolve_i.op == RES_CORRECT); // Oldest one, in order
    assign add_free_register_o = commit_i.valid & ~commit_i.exception; // Recycle old_pdst
    assign commit_roll_back_o  = rollback;
    assign roll_back_o         = rollback;

endmodule

// ==== verilog/fp_rename_top.sv ====
`timescale 1ns/1ps

module fp_rename_top import rename_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  rename_req_t  rename_i,   // From the front end
    input  resolve_t     resolve_i,  // From the branch unit
    input  commit_t      commit_i,   // From the reorder buffer
    output rename_resp_t rename_o,
    output logic         stall_o
);

    // Controller strobes
    logic read_head, do_checkpoint, do_recover, delete_checkpoint;
    logic add_free_register, commit_roll_back;
    logic map_write, checkpoint, recover, roll_back;

    // Free list status and data
    logic          empty, out_of_checkpoints;
    phfreg_t       new_register;
    checkpoint_ptr ckpt_label;   // Working version, label of a branch this cycle

    // Map lookups
    phfreg_t psrc1, psrc2, old_pdst;

    fp_rename_ctrl i_fp_rename_ctrl (
        .rename_i             (rename_i),
        .resolve_i            (resolve_i),
        .commit_i             (commit_i),
        .empty_i              (empty),
        .out_of_checkpoints_i (out_of_checkpoints),
        .read_head_o          (read_head),
        .do_checkpoint_o      (do_checkpoint),
        .do_recover_o         (do_recover),
        .delete_checkpoint_o  (delete_checkpoint),
        .add_free_register_o  (add_free_register),
        .commit_roll_back_o   (commit_roll_back),
        .map_write_o          (map_write),
        .checkpoint_o         (checkpoint),
        .recover_o            (recover),
        .roll_back_o          (roll_back),
        .stall_o              (stall_o)
    );

    fp_free_list i_fp_free_list (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .read_head_i          (read_head),
        .add_free_register_i  (add_free_register),
        .free_register_i      (commit_i.old_pdst),
        .do_checkpoint_i      (do_checkpoint),
        .do_recover_i         (do_recover),
        .delete_checkpoint_i  (delete_checkpoint),
        .recover_checkpoint_i (resolve_i.label),
        .commit_roll_back_i   (commit_roll_back),
        .new_register_o       (new_register),
        .checkpoint_o         (ckpt_label),
        .out_of_checkpoints_o (out_of_checkpoints),
        .empty_o              (empty)
    );

    fp_rename_table i_fp_rename_table (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .src1_i             (rename_i.src1),
        .src2_i             (rename_i.src2),
        .dst_i              (rename_i.dst),
        .map_write_i        (map_write),
        .new_preg_i         (new_register),
        .checkpoint_i       (checkpoint),
        .checkpoint_label_i (ckpt_label),         // Same slot the free list freezes
        .recover_i          (recover),
        .recover_label_i    (resolve_i.label),
        .roll_back_i        (roll_back),
        .commit_write_i     (add_free_register),  // Normal commit updates the committed map
        .commit_areg_i      (commit_i.areg),
        .commit_preg_i      (commit_i.pdst),
        .psrc1_o            (psrc1),
        .psrc2_o            (psrc2),
        .old_pdst_o         (old_pdst)
    );

    // Response, all combinational in the request cycle
    assign rename_o.psrc1      = psrc1;
    assign rename_o.psrc2      = psrc2;
    assign rename_o.pdst       = new_register;
    assign rename_o.old_pdst   = old_pdst;
    assign rename_o.checkpoint = ckpt_label;

endmodule

// ==== sim/tb_fp_rename.sv ====
`timescale 1ns/1ps
`include "rename_settings.svh"

module tb_fp_rename import rename_pkg::*; ();

    localparam int       NUM_AREGS      = `NUM_ISA_REGISTERS;
    localparam int       NUM_FREE       = `NUM_PHYSICAL_FREGISTERS - `NUM_ISA_REGISTERS;
    localparam int       NUM_SLOTS      = `NUM_CHECKPOINTS;
    localparam int       TIMEOUT_CYCLES = 2000; // Tests take about 200 cycles
    localparam logic [31:0] SEED        = 32'ha6b5_f170;
    localparam rename_req_t IDLE_REQ    = '0;
    localparam resolve_t    NO_RESOLVE  = '0;  // RES_NONE

    logic         clk_i;
    logic         rstn_i;
    rename_req_t  rename_in;
    resolve_t     resolve_in;
    commit_t      commit_in;
    rename_resp_t rename_out;
    logic         stall_out;

    // Reference model of the stage
    phfreg_t       model_map [0:NUM_AREGS-1];                // Speculative map
    phfreg_t       arch_map [0:NUM_AREGS-1];                 // Committed map
    phfreg_t       snap_map [0:NUM_SLOTS-1][0:NUM_AREGS-1];  // Map per checkpoint label
    int            snap_head [0:NUM_SLOTS-1];
    int            snap_rob [0:NUM_SLOTS-1];
    phfreg_t       free_seq [$];  // Every register put in the ring, in ring order
    int            head_idx;      // Next free_seq entry handed out
    commit_t       rob [$];       // In-flight FP destinations, oldest first
    checkpoint_ptr work_label;    // Label the next branch gets
    checkpoint_ptr oldest_label;
    int            live;          // Live checkpoints
    int            cycle_count = 0;
    string         test_name;

    fp_rename_top i_fp_rename_top (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .rename_i  (rename_in),
        .resolve_i (resolve_in),
        .commit_i  (commit_in),
        .rename_o  (rename_out),
        .stall_o   (stall_out)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Hard limit on the run length
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic int rand_areg();
        return int'($urandom % NUM_AREGS);
    endfunction

    function automatic rename_req_t make_req(input int src1, input int src2, input int dst,
                                             input logic dst_valid, input logic is_branch);
        rename_req_t r;
        r.valid     = 1'b1;
        r.src1      = areg_t'(src1);
        r.src2      = areg_t'(src2);
        r.dst       = areg_t'(dst);
        r.dst_valid = dst_valid;
        r.is_branch = is_branch;
        return r;
    endfunction

    function automatic resolve_t make_resolve(input resolve_op_e op, input checkpoint_ptr label);
        resolve_t r;
        r.op    = op;
        r.label = label;
        return r;
    endfunction

    task automatic init_model();
        for (int i = 0; i < NUM_AREGS; i++) begin
            model_map[i] = phfreg_t'(i);  // fN -> pN
            arch_map[i]  = phfreg_t'(i);
        end
        free_seq.delete();
        for (int i = 0; i < NUM_FREE; i++) free_seq.push_back(phfreg_t'(NUM_AREGS + i));
        rob.delete();
        head_idx     = 0;
        work_label   = '0;
        oldest_label = '0;
        live         = 0;
    endtask

    // One clock cycle: drive at the rising edge, check at the falling edge, update model
    task automatic run_cycle(input rename_req_t req, input resolve_t res,
                             input logic do_commit, input logic exception);
        commit_t com;
        commit_t entry;
        logic    mispredict;
        logic    rollback;
        logic    exp_stall;
        int      slot;
        com = '0;
        if (do_commit) begin
            com           = rob[0];  // Oldest in flight
            com.valid     = 1'b1;
            com.exception = exception;
        end
        @(posedge clk_i);
        rename_in  <= req;
        resolve_in <= res;
        commit_in  <= com;
        @(negedge clk_i);
        mispredict = (res.op == RES_MISPREDICT);
        rollback   = do_commit & exception;
        if (do_commit && !exception) begin  // Freed register usable in the same cycle
            arch_map[com.areg] = com.pdst;
            free_seq.push_back(com.old_pdst);
            void'(rob.pop_front());
            for (int s = 0; s < NUM_SLOTS; s++) snap_rob[s]--;
        end
        exp_stall = (req.valid & req.dst_valid & (head_idx >= free_seq.size()))
                  | (req.valid & req.is_branch & (live == NUM_SLOTS - 1))
                  | mispredict | rollback;
        check("stall_o", int'(exp_stall), int'(stall_out));
        if (req.valid && !exp_stall) begin
            check("psrc1", int'(model_map[req.src1]), int'(rename_out.psrc1));  // Old mapping
            check("psrc2", int'(model_map[req.src2]), int'(rename_out.psrc2));
            if (req.dst_valid) begin
                check("old_pdst", int'(model_map[req.dst]), int'(rename_out.old_pdst));
                check("pdst", int'(free_seq[head_idx]), int'(rename_out.pdst));
                entry          = '0;
                entry.areg     = req.dst;
                entry.pdst     = free_seq[head_idx];
                entry.old_pdst = model_map[req.dst];
                rob.push_back(entry);
                model_map[req.dst] = free_seq[head_idx];
                head_idx++;
            end
            if (req.is_branch) begin
                // Snapshot includes the branch's own write
                check("checkpoint", int'(work_label), int'(rename_out.checkpoint));
                for (int i = 0; i < NUM_AREGS; i++) snap_map[work_label][i] = model_map[i];
                snap_head[work_label] = head_idx;
                snap_rob[work_label]  = rob.size();
                work_label++;
                live++;
            end
        end
        if (res.op == RES_CORRECT) begin  // Oldest checkpoint released
            oldest_label++;
            live--;
        end
        if (mispredict) begin
            slot = int'(res.label);
            for (int i = 0; i < NUM_AREGS; i++) model_map[i] = snap_map[slot][i];
            head_idx = snap_head[slot];
            while (rob.size() > snap_rob[slot]) void'(rob.pop_back());  // Squash younger
            work_label = res.label;
            live       = int'(checkpoint_ptr'(res.label - oldest_label));
        end
        if (rollback) begin
            for (int i = 0; i < NUM_AREGS; i++) model_map[i] = arch_map[i];
            head_idx     = free_seq.size() - NUM_FREE;  // Whole ring free again
            rob.delete();
            work_label   = '0;
            oldest_label = '0;
            live         = 0;
        end
    endtask

    // Reads every architectural register through the source ports
    task automatic sweep_lookups();
        for (int i = 0; i < NUM_AREGS; i += 2) begin
            run_cycle(make_req(i, i + 1, 0, 1'b0, 1'b0), NO_RESOLVE, 1'b0, 1'b0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_straight_rename();
        test_name = "straight_rename";
        for (int i = 0; i < 10; i++) begin
            run_cycle(make_req(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0),
                      NO_RESOLVE, 1'b0, 1'b0);
            check("pdst order", NUM_AREGS + i, int'(rename_out.pdst));
        end
        sweep_lookups();
    endtask

    task automatic test_empty_stall();
        rename_req_t req;
        test_name = "empty_stall";
        while (head_idx < free_seq.size()) begin  // Drain the ring
            run_cycle(make_req(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0),
                      NO_RESOLVE, 1'b0, 1'b0);
        end
        req = make_req(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0);
        repeat (3) begin  // Front end holds it
            run_cycle(req, NO_RESOLVE, 1'b0, 1'b0);
            check("stall while empty", 1, int'(stall_out));
        end
        run_cycle(req, NO_RESOLVE, 1'b1, 1'b0);  // Commit frees one, bypassed to pdst
        check("stall with commit", 0, int'(stall_out));
    endtask

    task automatic test_commit_recycle();
        phfreg_t freed [$];
        test_name = "commit_recycle";
        for (int i = 0; i < 8; i++) begin
            freed.push_back(rob[0].old_pdst);
            run_cycle(IDLE_REQ, NO_RESOLVE, 1'b1, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            run_cycle(make_req(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0),
                      NO_RESOLVE, 1'b0, 1'b0);
            check("recycled pdst", int'(freed[i]), int'(rename_out.pdst));  // FIFO order
        end
    endtask

    task automatic test_recover();
        checkpoint_ptr label;
        phfreg_t       resume_pdst;
        test_name = "checkpoint_recover";
        repeat (12) run_cycle(IDLE_REQ, NO_RESOLVE, 1'b1, 1'b0);
        run_cycle(make_req(rand_areg(), rand_areg(), 0, 1'b0, 1'b1), NO_RESOLVE, 1'b0, 1'b0);
        label       = rename_out.checkpoint;
        resume_pdst = free_seq[head_idx];  // Head at the branch
        repeat (4) begin
            run_cycle(make_req(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0),
                      NO_RESOLVE, 1'b0, 1'b0);
        end
        run_cycle(IDLE_REQ, make_resolve(RES_MISPREDICT, label), 1'b0, 1'b0);
        sweep_lookups();
        run_cycle(make_req(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0),
                  NO_RESOLVE, 1'b0, 1'b0);
        check("pdst after recover", int'(resume_pdst), int'(rename_out.pdst));
    endtask

    task automatic test_checkpoint_limit();
        rename_req_t branch;
        test_name = "checkpoint_limit";
        repeat (3) begin
            run_cycle(make_req(rand_areg(), rand_areg(), 0, 1'b0, 1'b1), NO_RESOLVE, 1'b0, 1'b0);
        end
        branch = make_req(rand_areg(), rand_areg(), 0, 1'b0, 1'b1);
        run_cycle(branch, NO_RESOLVE, 1'b0, 1'b0);
        check("stall on fourth branch", 1, int'(stall_out));
        // Release lands at this edge, the branch still waits one cycle
        run_cycle(branch, make_resolve(RES_CORRECT, oldest_label), 1'b0, 1'b0);
        check("stall during release", 1, int'(stall_out));
        run_cycle(branch, NO_RESOLVE, 1'b0, 1'b0);
        check("stall after release", 0, int'(stall_out));
        repeat (3) run_cycle(IDLE_REQ, make_resolve(RES_CORRECT, oldest_label), 1'b0, 1'b0);
    endtask

    task automatic test_rollback();
        test_name = "exception_rollback";
        repeat (5) begin
            run_cycle(make_req(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0),
                      NO_RESOLVE, 1'b0, 1'b0);
        end
        repeat (2) run_cycle(IDLE_REQ, NO_RESOLVE, 1'b1, 1'b0);
        run_cycle(IDLE_REQ, NO_RESOLVE, 1'b1, 1'b1);  // Excepting commit
        sweep_lookups();                              // Model map is the committed map now
        for (int i = 0; i < NUM_FREE; i++) begin
            run_cycle(make_req(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0),
                      NO_RESOLVE, 1'b0, 1'b0);
            check("stall after rollback", 0, int'(stall_out));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rename_in  = '0;
        resolve_in = '0;
        commit_in  = '0;
        rstn_i     = 1'b0;
        init_model();
        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;
        test_straight_rename();
        test_empty_stall();
        test_commit_recycle();
        test_recover();
        test_checkpoint_limit();
        test_rollback();
        run_cycle(IDLE_REQ, NO_RESOLVE, 1'b0, 1'b0);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/fp_free_list.sv
verilog/fp_rename_table.sv
verilog/fp_rename_ctrl.sv
verilog/fp_rename_top.sv
sim/tb_fp_rename.sv

// ==== run.sh ====
#!/bin/sh
# Build the FP rename testbench with Verilator and run it
# The result is read from sim.log

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_fp_rename -f tb.f -o tb_fp_rename \
    && ./obj_dir/tb_fp_rename > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
